// File: logic/rv_core_pkg.sv
`default_nettype none

package rv_core_pkg;

  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;

  typedef logic [reg_addr_w-1:0] reg_idx_t;
  typedef logic [xlen-1:0]       word_t;

  // ALU operations plus alu_pass for LUI
  typedef enum logic [3:0] {
    alu_add  = 4'd0,
    alu_sub  = 4'd1,
    alu_and  = 4'd2,
    alu_or   = 4'd3,
    alu_xor  = 4'd4,
    alu_slt  = 4'd5,
    alu_sltu = 4'd6,
    alu_sll  = 4'd7,
    alu_srl  = 4'd8,
    alu_sra  = 4'd9,
    alu_pass = 4'd10
  } alu_op_t;

  // Encodings follow funct3 of the branch group where one exists
  typedef enum logic [2:0] {
    br_eq   = 3'b000,
    br_ne   = 3'b001,
    br_none = 3'b010,
    br_lt   = 3'b100,
    br_ge   = 3'b101,
    br_ltu  = 3'b110,
    br_geu  = 3'b111
  } branch_cond_t;

  // Major opcodes kept by this core
  typedef enum logic [6:0] {
    opc_op     = 7'b0110011,
    opc_op_imm = 7'b0010011,
    opc_lui    = 7'b0110111,
    opc_branch = 7'b1100011,
    opc_jal    = 7'b1101111,
    opc_system = 7'b1110011
  } opcode_t;

  // ADDI x0, x0, 0
  localparam word_t nop_word = 32'h0000_0013;

endpackage

`default_nettype wire

// File: logic/issue_if.sv
`timescale 1ns/100ps
`default_nettype none

// One decoded instruction on its way from decode to execute
interface issue_if
  import rv_core_pkg::*;
();

  logic         valid;
  word_t        pc;
  reg_idx_t     rd;
  word_t        op1;
  word_t        op2;
  alu_op_t      alu_op;
  branch_cond_t branch_cond;
  word_t        branch_offset;
  logic         is_jal;
  logic         writes_rd;
  logic         is_halt;

  modport decoder (
    output valid, pc, rd, op1, op2, alu_op, branch_cond, branch_offset,
    output is_jal, writes_rd, is_halt
  );

  modport execute (
    input valid, pc, rd, op1, op2, alu_op, branch_cond, branch_offset,
    input is_jal, writes_rd, is_halt
  );

  modport monitor (
    input valid, is_halt
  );

endinterface

`default_nettype wire

// File: logic/fetch_unit.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_unit
  import rv_core_pkg::*;
#(
  parameter word_t RESET_PC = 32'h0000_0000
)
(
  input  wire   clk_i,
  input  wire   reset_i,
  input  wire   fetch_accept_i,
  input  wire   redirect_i,
  input  word_t redirect_pc_i,
  input  word_t imem_data_i,
  output word_t imem_addr_o,
  output word_t instr_o,
  output word_t instr_pc_o
);

  word_t pc_q;
  word_t instr_q;
  word_t instr_pc_q;

  //////////////////////////////////////////////////
  // Program counter
  //////////////////////////////////////////////////

  // Redirect wins over a normal advance
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pc_q <= RESET_PC;
    end else if (redirect_i) begin
      pc_q <= redirect_pc_i;
    end else if (fetch_accept_i) begin
      pc_q <= pc_q + 32'd4;
    end
  end

  assign imem_addr_o = pc_q;

  //////////////////////////////////////////////////
  // Fetch to decode register
  //////////////////////////////////////////////////

  // A flushed slot holds a harmless ADDI
  always_ff @(posedge clk_i) begin
    if (redirect_i) begin
      instr_q <= nop_word;
    end else if (fetch_accept_i) begin
      instr_q    <= imem_data_i;
      instr_pc_q <= pc_q;
    end
  end

  assign instr_o    = instr_q;
  assign instr_pc_o = instr_pc_q;

endmodule

`default_nettype wire

// File: logic/instr_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module instr_decoder
  import rv_core_pkg::*;
(
  input  wire         clk_i,
  input  wire         reset_i,
  input  word_t       instr_i,
  input  word_t       instr_pc_i,
  input  wire         decode_valid_i,
  input  wire         flush_i,
  output reg_idx_t    rs1_o,
  output reg_idx_t    rs2_o,
  input  word_t       rs1_data_i,
  input  word_t       rs2_data_i,
  input  wire         fwd_valid_i,
  input  reg_idx_t    fwd_rd_i,
  input  word_t       fwd_data_i,
  issue_if.decoder    issue
);

  opcode_t      opcode;
  logic [2:0]   funct3;
  logic         funct7_alt;
  word_t        imm_i;
  word_t        imm_b;
  word_t        imm_u;
  word_t        imm_j;
  word_t        rs1_val;
  word_t        rs2_val;
  reg_idx_t     rd_d;
  word_t        op1_d;
  word_t        op2_d;
  alu_op_t      alu_op_d;
  branch_cond_t cond_d;
  word_t        offset_d;
  logic         is_jal_d;
  logic         writes_rd_d;
  logic         is_halt_d;

  // funct3 to ALU operation, alt selects SUB or SRA
  function automatic alu_op_t alu_sel(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? alu_sub : alu_add;
      3'b001:  return alu_sll;
      3'b010:  return alu_slt;
      3'b011:  return alu_sltu;
      3'b100:  return alu_xor;
      3'b101:  return alt ? alu_sra : alu_srl;
      3'b110:  return alu_or;
      default: return alu_and;
    endcase
  endfunction

  //////////////////////////////////////////////////
  // Fields and immediates
  //////////////////////////////////////////////////

  assign opcode     = opcode_t'(instr_i[6:0]);
  assign funct3     = instr_i[14:12];
  assign funct7_alt = instr_i[30];
  assign rs1_o      = instr_i[19:15];
  assign rs2_o      = instr_i[24:20];

  assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                  instr_i[11:8], 1'b0};
  assign imm_u = {instr_i[31:12], 12'b0};
  assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                  instr_i[30:21], 1'b0};

  // Execute result bypasses the register file write
  assign rs1_val = (fwd_valid_i && fwd_rd_i == rs1_o && rs1_o != '0) ? fwd_data_i : rs1_data_i;
  assign rs2_val = (fwd_valid_i && fwd_rd_i == rs2_o && rs2_o != '0) ? fwd_data_i : rs2_data_i;

  always_comb begin
    rd_d        = '0;
    op1_d       = rs1_val;
    op2_d       = rs2_val;
    alu_op_d    = alu_add;
    cond_d      = br_none;
    offset_d    = imm_j;
    is_jal_d    = 1'b0;
    writes_rd_d = 1'b0;
    is_halt_d   = 1'b0;
    case (opcode)
      opc_op: begin
        rd_d        = instr_i[11:7];
        alu_op_d    = alu_sel(funct3, funct7_alt);
        writes_rd_d = 1'b1;
      end
      opc_op_imm: begin
        rd_d        = instr_i[11:7];
        op2_d       = imm_i;
        // Only shifts use bit 30 in the immediate group
        alu_op_d    = alu_sel(funct3, funct3 == 3'b101 && funct7_alt);
        writes_rd_d = 1'b1;
      end
      opc_lui: begin
        rd_d        = instr_i[11:7];
        op2_d       = imm_u;
        alu_op_d    = alu_pass;
        writes_rd_d = 1'b1;
      end
      opc_branch: begin
        offset_d = imm_b;
        case (funct3)
          3'b000:  cond_d = br_eq;
          3'b001:  cond_d = br_ne;
          3'b100:  cond_d = br_lt;
          3'b101:  cond_d = br_ge;
          3'b110:  cond_d = br_ltu;
          3'b111:  cond_d = br_geu;
          default: cond_d = br_none;
        endcase
      end
      opc_jal: begin
        rd_d        = instr_i[11:7];
        is_jal_d    = 1'b1;
        writes_rd_d = 1'b1;
      end
      opc_system: begin
        is_halt_d = (funct3 == 3'b000) && (instr_i[31:20] == 12'h001);
      end
      default: begin
        // Unknown opcodes fall through as a no-op
      end
    endcase
  end

  //////////////////////////////////////////////////
  // Decode to execute register
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      issue.valid <= 1'b0;
    end else begin
      issue.valid <= decode_valid_i & ~flush_i;
    end
  end

  always_ff @(posedge clk_i) begin
    issue.pc            <= instr_pc_i;
    issue.rd            <= rd_d;
    issue.op1           <= op1_d;
    issue.op2           <= op2_d;
    issue.alu_op        <= alu_op_d;
    issue.branch_cond   <= cond_d;
    issue.branch_offset <= offset_d;
    issue.is_jal        <= is_jal_d;
    issue.writes_rd     <= writes_rd_d;
    issue.is_halt       <= is_halt_d;
  end

endmodule

`default_nettype wire

// File: logic/reg_file.sv
`timescale 1ns/100ps
`default_nettype none

module reg_file
  import rv_core_pkg::*;
(
  input  wire      clk_i,
  input  wire      we_i,
  input  reg_idx_t wr_rd_i,
  input  word_t    wr_data_i,
  input  reg_idx_t rs1_i,
  input  reg_idx_t rs2_i,
  output word_t    rs1_data_o,
  output word_t    rs2_data_o
);

  // x0 has no storage
  word_t regs [1:31];

  always_ff @(posedge clk_i) begin
    if (we_i && wr_rd_i != '0) begin
      regs[wr_rd_i] <= wr_data_i;
    end
  end

  // Asynchronous reads, the write lands at the clock edge
  assign rs1_data_o = (rs1_i == '0) ? '0 : regs[rs1_i];
  assign rs2_data_o = (rs2_i == '0) ? '0 : regs[rs2_i];

endmodule

`default_nettype wire

// File: logic/execute_unit.sv
`timescale 1ns/100ps
`default_nettype none

module execute_unit
  import rv_core_pkg::*;
(
  input  wire      clk_i,
  input  wire      reset_i,
  input  wire      halted_i,
  issue_if.execute issue,
  output logic     redirect_o,
  output word_t    redirect_pc_o,
  output logic     wr_en_o,
  output reg_idx_t wr_rd_o,
  output word_t    wr_data_o,
  output logic     retire_valid_o,
  output word_t    retire_pc_o,
  output reg_idx_t retire_rd_o,
  output word_t    retire_data_o
);

  logic       ex_valid;
  logic [4:0] shamt;
  word_t      alu_res;
  word_t      link;
  word_t      result;
  logic       taken;

  assign ex_valid = issue.valid & ~halted_i;
  assign shamt    = issue.op2[4:0];
  assign link     = issue.pc + 32'd4;

  //////////////////////////////////////////////////
  // ALU and branch compare
  //////////////////////////////////////////////////

  always_comb begin
    case (issue.alu_op)
      alu_add:  alu_res = issue.op1 + issue.op2;
      alu_sub:  alu_res = issue.op1 - issue.op2;
      alu_and:  alu_res = issue.op1 & issue.op2;
      alu_or:   alu_res = issue.op1 | issue.op2;
      alu_xor:  alu_res = issue.op1 ^ issue.op2;
      alu_slt:  alu_res = {31'b0, $signed(issue.op1) < $signed(issue.op2)};
      alu_sltu: alu_res = {31'b0, issue.op1 < issue.op2};
      alu_sll:  alu_res = issue.op1 << shamt;
      alu_srl:  alu_res = issue.op1 >> shamt;
      alu_sra:  alu_res = word_t'($signed(issue.op1) >>> shamt);
      alu_pass: alu_res = issue.op2;
      default:  alu_res = '0;
    endcase
  end

  always_comb begin
    case (issue.branch_cond)
      br_eq:   taken = (issue.op1 == issue.op2);
      br_ne:   taken = (issue.op1 != issue.op2);
      br_lt:   taken = ($signed(issue.op1) < $signed(issue.op2));
      br_ge:   taken = ($signed(issue.op1) >= $signed(issue.op2));
      br_ltu:  taken = (issue.op1 < issue.op2);
      br_geu:  taken = (issue.op1 >= issue.op2);
      default: taken = 1'b0;
    endcase
  end

  // JAL links pc+4
  assign result = issue.is_jal ? link : alu_res;

  // Redirect lasts exactly as long as the instruction sits here
  assign redirect_o    = ex_valid & (issue.is_jal | taken);
  assign redirect_pc_o = issue.pc + issue.branch_offset;

  //////////////////////////////////////////////////
  // Writeback and retire trace
  //////////////////////////////////////////////////

  assign wr_en_o   = ex_valid & issue.writes_rd & ~issue.is_halt & (issue.rd != '0);
  assign wr_rd_o   = issue.rd;
  assign wr_data_o = result;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      retire_valid_o <= 1'b0;
    end else begin
      retire_valid_o <= ex_valid & ~issue.is_halt;
    end
  end

  always_ff @(posedge clk_i) begin
    retire_pc_o   <= issue.pc;
    retire_rd_o   <= issue.rd;
    retire_data_o <= result;
  end

endmodule

`default_nettype wire

// File: logic/pipeline_control.sv
`timescale 1ns/100ps
`default_nettype none

module pipeline_control
  import rv_core_pkg::*;
(
  input  wire      clk_i,
  input  wire      reset_i,
  input  wire      imem_valid_i,
  input  wire      redirect_i,
  issue_if.monitor issue,
  output logic     fetch_accept_o,
  output logic     flush_o,
  output logic     decode_valid_o,
  output logic     halted_o
);

  logic halt_in_ex;
  logic halt_block;
  logic decode_valid_q;
  logic halted_q;

  // EBREAK sitting in execute
  assign halt_in_ex = issue.valid & issue.is_halt;
  assign halt_block = halted_q | halt_in_ex;

  //////////////////////////////////////////////////
  // Fetch accept and flush
  //////////////////////////////////////////////////

  // Target of a redirect is fetched on the following cycle
  assign fetch_accept_o = imem_valid_i & ~halt_block & ~redirect_i;

  // Anything younger than a redirect or a halt is dropped
  assign flush_o = redirect_i | halt_in_ex;

  //////////////////////////////////////////////////
  // Decode valid and halt state
  //////////////////////////////////////////////////

  // A stalled fetch leaves a bubble in decode
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      decode_valid_q <= 1'b0;
    end else begin
      decode_valid_q <= fetch_accept_o & ~flush_o;
    end
  end

  // Sticky until reset
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      halted_q <= 1'b0;
    end else if (halt_in_ex) begin
      halted_q <= 1'b1;
    end
  end

  assign decode_valid_o = decode_valid_q;
  assign halted_o       = halted_q;

endmodule

`default_nettype wire

// File: logic/rv_core_top.sv
`timescale 1ns/100ps
`default_nettype none

module rv_core_top
  import rv_core_pkg::*;
#(
  parameter word_t RESET_PC = 32'h0000_0000
)
(
  input  wire      clk_i,
  input  wire      reset_i,
  output word_t    imem_addr_o,
  input  word_t    imem_data_i,
  input  wire      imem_valid_i,
  output logic     retire_valid_o,
  output word_t    retire_pc_o,
  output reg_idx_t retire_rd_o,
  output word_t    retire_data_o,
  output logic     halted_o
);

  logic     fetch_accept;
  logic     flush;
  logic     decode_valid;
  logic     redirect;
  word_t    redirect_pc;
  word_t    instr;
  word_t    instr_pc;
  reg_idx_t rs1;
  reg_idx_t rs2;
  word_t    rs1_data;
  word_t    rs2_data;
  logic     wr_en;
  reg_idx_t wr_rd;
  word_t    wr_data;

  issue_if issue ();

  //////////////////////////////////////////////////
  // Stages
  //////////////////////////////////////////////////

  fetch_unit #(
    .RESET_PC (RESET_PC)
  ) u_fetch (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .fetch_accept_i (fetch_accept),
    .redirect_i     (redirect),
    .redirect_pc_i  (redirect_pc),
    .imem_data_i    (imem_data_i),
    .imem_addr_o    (imem_addr_o),
    .instr_o        (instr),
    .instr_pc_o     (instr_pc)
  );

  instr_decoder u_decode (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .instr_i        (instr),
    .instr_pc_i     (instr_pc),
    .decode_valid_i (decode_valid),
    .flush_i        (flush),
    .rs1_o          (rs1),
    .rs2_o          (rs2),
    .rs1_data_i     (rs1_data),
    .rs2_data_i     (rs2_data),
    .fwd_valid_i    (wr_en),
    .fwd_rd_i       (wr_rd),
    .fwd_data_i     (wr_data),
    .issue          (issue.decoder)
  );

  reg_file u_regs (
    .clk_i      (clk_i),
    .we_i       (wr_en),
    .wr_rd_i    (wr_rd),
    .wr_data_i  (wr_data),
    .rs1_i      (rs1),
    .rs2_i      (rs2),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data)
  );

  execute_unit u_execute (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .halted_i       (halted_o),
    .issue          (issue.execute),
    .redirect_o     (redirect),
    .redirect_pc_o  (redirect_pc),
    .wr_en_o        (wr_en),
    .wr_rd_o        (wr_rd),
    .wr_data_o      (wr_data),
    .retire_valid_o (retire_valid_o),
    .retire_pc_o    (retire_pc_o),
    .retire_rd_o    (retire_rd_o),
    .retire_data_o  (retire_data_o)
  );

  pipeline_control u_control (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .imem_valid_i   (imem_valid_i),
    .redirect_i     (redirect),
    .issue          (issue.monitor),
    .fetch_accept_o (fetch_accept),
    .flush_o        (flush),
    .decode_valid_o (decode_valid),
    .halted_o       (halted_o)
  );

endmodule

`default_nettype wire

// File: dv/rv_core_tb.sv
`timescale 1ns/100ps
`default_nettype none

module rv_core_tb;
  import rv_core_pkg::*;

  localparam int mem_words = 256;
  localparam int reset_cycles = 16;
  localparam int tail_cycles = 8;

  logic     clk_i;
  logic     reset_i;
  word_t    imem_addr;
  word_t    imem_data;
  logic     imem_valid;
  logic     retire_valid;
  word_t    retire_pc;
  reg_idx_t retire_rd;
  word_t    retire_data;
  logic     halted;

  // Program image of the running test
  word_t mem [0:mem_words-1];
  bit    mem_set [0:mem_words-1];

  // Contents of the cases file, one entry per program line
  string    names[$];
  int       ln_test[$];
  word_t    ln_addr[$];
  word_t    ln_word[$];
  bit       ln_ret[$];
  reg_idx_t ln_rd[$];
  word_t    ln_data[$];

  // Expected retire sequence of the running test
  word_t    exp_pc[$];
  reg_idx_t exp_rd[$];
  word_t    exp_data[$];
  int       exp_idx;

  string       cur_name;
  bit          checking;
  bit          stall_enable;
  logic [31:0] lcg_state;
  int          error_count;
  int          budget;
  bit          budget_ready;
  int          total_entries;

  rv_core_top #(
    .RESET_PC (32'h0000_0000)
  ) uut (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .imem_addr_o    (imem_addr),
    .imem_data_i    (imem_data),
    .imem_valid_i   (imem_valid),
    .retire_valid_o (retire_valid),
    .retire_pc_o    (retire_pc),
    .retire_rd_o    (retire_rd),
    .retire_data_o  (retire_data),
    .halted_o       (halted)
  );

  always #50 clk_i = ~clk_i;

  //////////////////////////////////////////////////
  // Instruction memory and fetch stalls
  //////////////////////////////////////////////////

  // LUI x0 with an address dependent immediate, retires with a wrong pc if reached
  function automatic word_t fill_word(input word_t addr);
    return {addr[31:12] ^ {10'b0, addr[11:2]}, 5'd0, 7'b0110111};
  endfunction

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  assign imem_data = (imem_addr[31:10] == '0 && mem_set[imem_addr[9:2]]) ?
                     mem[imem_addr[9:2]] : fill_word(imem_addr);

  // Quarter of the draws give a bubble
  always @(posedge clk_i) begin
    lcg_state <= lcg_next(lcg_state);
    if (stall_enable) begin
      imem_valid <= (lcg_state >= 32'h4000_0000);
    end else begin
      imem_valid <= 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  task automatic compare(input string what, input logic [31:0] expected,
                         input logic [31:0] actual);
    if (expected !== actual) begin
      error_count++;
      $display("error %s %s: expected %h, actual %h", cur_name, what, expected, actual);
    end
  endtask

  // Retire outputs are registered, so the falling edge sees them settled
  always @(negedge clk_i) begin
    if (checking && retire_valid) begin
      if (halted) begin
        error_count++;
        $display("Instruction retired after halt at pc %h in test %s", retire_pc, cur_name);
      end else if (exp_idx >= exp_pc.size()) begin
        error_count++;
        $display("Unexpected extra retire at pc %h in test %s", retire_pc, cur_name);
      end else begin
        compare("pc", exp_pc[exp_idx], retire_pc);
        compare("rd", {27'b0, exp_rd[exp_idx]}, {27'b0, retire_rd});
        if (exp_rd[exp_idx] != '0) begin
          compare("data", exp_data[exp_idx], retire_data);
        end
        exp_idx++;
      end
    end
  end

  //////////////////////////////////////////////////
  // Cases file and test runs
  //////////////////////////////////////////////////

  // Lines: test <name> | r <addr> <word> <rd> <data> | p <addr> <word>
  task automatic load_cases(output bit ok);
    integer fd;
    integer code;
    integer rd;
    string  tok;
    string  rest;
    word_t  a;
    word_t  w;
    word_t  d;
    ok = 1'b0;
    fd = $fopen("dv/rv_core_cases.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the cases file dv/rv_core_cases.txt");
      return;
    end
    ok = 1'b1;
    while ($fscanf(fd, "%s", tok) == 1) begin
      if (tok.substr(0, 0) == "#") begin
        code = $fgets(rest, fd);
      end else if (tok == "test") begin
        code = $fscanf(fd, "%s", tok);
        names.push_back(tok);
      end else if ((tok == "r" || tok == "p") && names.size() > 0) begin
        code = $fscanf(fd, "%h %h", a, w);
        rd = 0;
        d = '0;
        if (tok == "r") begin
          code = $fscanf(fd, "%d %h", rd, d);
          total_entries++;
        end
        ln_test.push_back(names.size() - 1);
        ln_addr.push_back(a);
        ln_word.push_back(w);
        ln_ret.push_back(tok == "r");
        ln_rd.push_back(reg_idx_t'(rd));
        ln_data.push_back(d);
      end else begin
        $display("Unknown token %s in the cases file", tok);
        ok = 1'b0;
      end
    end
    $fclose(fd);
  endtask

  task automatic run_test(input int t, input bit stalls);
    for (int i = 0; i < mem_words; i++) begin
      mem_set[i] = 1'b0;
      mem[i] = '0;
    end
    exp_pc.delete();
    exp_rd.delete();
    exp_data.delete();
    for (int i = 0; i < ln_test.size(); i++) begin
      if (ln_test[i] == t) begin
        mem[ln_addr[i][9:2]] = ln_word[i];
        mem_set[ln_addr[i][9:2]] = 1'b1;
        if (ln_ret[i]) begin
          exp_pc.push_back(ln_addr[i]);
          exp_rd.push_back(ln_rd[i]);
          exp_data.push_back(ln_data[i]);
        end
      end
    end
    cur_name = stalls ? {names[t], "_stall"} : names[t];
    stall_enable = stalls;
    exp_idx = 0;
    @(posedge clk_i);
    reset_i <= 1'b1;
    repeat (reset_cycles) @(posedge clk_i);
    reset_i <= 1'b0;
    checking = 1'b1;
    while (halted !== 1'b1) @(negedge clk_i);
    // Nothing may retire once halted
    repeat (tail_cycles) @(negedge clk_i);
    checking = 1'b0;
    compare("retire count", exp_pc.size(), exp_idx);
    compare("halted", 32'd1, {31'b0, halted});
  endtask

  // Watchdog sized from the number of expected retires
  initial begin
    wait (budget_ready);
    repeat (budget) @(posedge clk_i);
    $display("Watchdog timeout: the run did not finish within %0d cycles", budget);
    $display("Verification failed");
    $finish;
  end

  initial begin
    bit ok;
    clk_i = 1'b0;
    reset_i = 1'b1;
    imem_valid = 1'b0;
    lcg_state = 32'h601e_7ea3;
    stall_enable = 1'b0;
    checking = 1'b0;
    error_count = 0;
    total_entries = 0;
    budget_ready = 1'b0;
    cur_name = "none";
    load_cases(ok);
    if (!ok || names.size() == 0) begin
      error_count++;
      $display("No usable tests were loaded");
    end else begin
      // Every test runs once clean and once with fetch stalls
      budget = 20 * 2 * total_entries + 200 + 2 * names.size() * (reset_cycles + tail_cycles);
      budget_ready = 1'b1;
      for (int t = 0; t < names.size(); t++) begin
        run_test(t, 1'b0);
        run_test(t, 1'b1);
      end
    end
    $display("Errors: %0d", error_count);
    if (error_count == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: dv/rv_core_cases.txt
# test <name> starts a program; r <pc> <word> <rd> <data> retires with rd and data
# p <pc> <word> is loaded but never retires; pc, word, data in hex, rd in decimal
test alu
r 00 00500093 1 00000005
r 04 ffd00113 2 fffffffd
r 08 002081b3 3 00000002
r 0c 40208233 4 00000008
r 10 0020f2b3 5 00000005
r 14 0020e333 6 fffffffd
r 18 0020c3b3 7 fffffff8
r 1c 00112433 8 00000001
r 20 001134b3 9 00000000
r 24 00111533 10 ffffffa0
r 28 001155b3 11 07ffffff
r 2c 40115633 12 ffffffff
r 30 123456b7 13 12345000
r 34 0ff6c713 14 123450ff
r 38 70076793 15 123457ff
r 3c ff07f813 16 123457f0
r 40 ffe12893 17 00000001
r 44 0060b913 18 00000001
r 48 00409993 19 00000050
r 4c 01c15a13 20 0000000f
r 50 40115a93 21 fffffffe
r 54 00708013 0 00000000
r 58 00000b33 22 00000000
p 5c 00100073
test branch
r 00 00500093 1 00000005
r 04 ffd00113 2 fffffffd
r 08 00208663 0 00000000
r 0c 00209663 0 00000000
r 18 0020c663 0 00000000
r 1c 0020d663 0 00000000
r 28 0020e663 0 00000000
r 34 0020f663 0 00000000
r 38 00108663 0 00000000
r 44 00109663 0 00000000
r 48 00114663 0 00000000
r 54 00115663 0 00000000
r 58 00116663 0 00000000
r 5c 00117663 0 00000000
r 68 00c002ef 5 0000006c
p 74 00100073

// File: rv_core.f
logic/rv_core_pkg.sv
logic/issue_if.sv
logic/fetch_unit.sv
logic/instr_decoder.sv
logic/reg_file.sv
logic/execute_unit.sv
logic/pipeline_control.sv
logic/rv_core_top.sv
dv/rv_core_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f rv_core.f --top-module rv_core_tb -o rv_core_sim
if [ $? -ne 0 ]; then
  echo "Build failed"
  exit 1
fi

out=$(./obj_dir/rv_core_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "Verification passed"; then
  exit 0
fi
exit 1
